// ==== Makefile ====
# Verilator lint and simulation of the memory subsystem testbench

VERILATOR  ?= verilator
TOP        ?= tb_mem_subsystem
FILELIST   ?= all.f
BUILD_DIR  ?= build
LOG        ?= $(BUILD_DIR)/sim.log
PASS_MSG   ?= *** TEST PASSED ***
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= --lint-only

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
	  --Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(SIM_BIN)
	@$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR)

// ==== all.f ====
src/axil_pkg.sv
src/mem_req_pkg.sv
src/mem_port_arbiter.sv
src/axil_master_bridge.sv
src/axil_sram_slave.sv
src/mem_subsystem_top.sv
test/tb_mem_subsystem.sv

// ==== src/axil_master_bridge.sv ====
// AXI-lite master; runs one read or write transaction per core request and returns the result
`timescale 1ns/1ps

module axil_master_bridge (
  input  logic                  i_aclk,
  input  logic                  i_rst,
  input  logic                  i_req_valid,
  output logic                  o_req_ready,
  input  mem_req_pkg::mem_req_t i_req,
  output logic                  o_rsp_valid,
  input  logic                  i_rsp_ready,
  output mem_req_pkg::mem_rsp_t o_rsp,
  output logic                  o_aw_valid,
  input  logic                  i_aw_ready,
  output axil_pkg::axil_aw_t    o_aw,
  output logic                  o_w_valid,
  input  logic                  i_w_ready,
  output axil_pkg::axil_w_t     o_w,
  input  logic                  i_b_valid,
  output logic                  o_b_ready,
  input  axil_pkg::axil_b_t     i_b,
  output logic                  o_ar_valid,
  input  logic                  i_ar_ready,
  output axil_pkg::axil_ar_t    o_ar,
  input  logic                  i_r_valid,
  output logic                  o_r_ready,
  input  axil_pkg::axil_r_t     i_r
);
  import axil_pkg::*;
  import mem_req_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    READ_ADDR,
    READ_DATA,
    WRITE_REQ,
    WRITE_RESP,
    RESPOND
  } bridge_state_e;

  bridge_state_e state_q;
  mem_req_t      req_q;
  mem_rsp_t      rsp_q;
  logic          aw_done_q;
  logic          w_done_q;
  logic          req_fire;
  logic          rsp_fire;
  logic          aw_fire;
  logic          w_fire;
  logic          b_fire;
  logic          ar_fire;
  logic          r_fire;

  assign rsp_fire = o_rsp_valid && i_rsp_ready;
  assign aw_fire  = o_aw_valid && i_aw_ready;
  assign w_fire   = o_w_valid && i_w_ready;
  assign b_fire   = i_b_valid && o_b_ready;
  assign ar_fire  = o_ar_valid && i_ar_ready;
  assign r_fire   = i_r_valid && o_r_ready;

  // Next request may land on the edge that retires the current one
  assign o_req_ready = i_req_valid && (state_q == IDLE || (state_q == RESPOND && i_rsp_ready));
  assign req_fire    = i_req_valid && o_req_ready;

  // ----------------------------------------
  // Transaction FSM
  // ----------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      state_q   <= IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      case (state_q)
        IDLE, RESPOND: begin
          if (req_fire) begin
            state_q <= i_req.write ? WRITE_REQ : READ_ADDR;
          end else if (state_q == IDLE || rsp_fire) begin
            state_q <= IDLE;
          end
        end
        READ_ADDR:  if (ar_fire) state_q <= READ_DATA;
        READ_DATA:  if (r_fire) state_q <= RESPOND;
        WRITE_REQ: begin
          if (aw_fire) aw_done_q <= 1'b1;
          if (w_fire) w_done_q <= 1'b1;
          // AW and W may finish in either order
          if ((aw_done_q || aw_fire) && (w_done_q || w_fire)) begin
            state_q   <= WRITE_RESP;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
          end
        end
        WRITE_RESP: if (b_fire) state_q <= RESPOND;
        default:    state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (req_fire) begin
      req_q <= i_req;
    end
    if (r_fire) begin
      rsp_q <= '{id: req_q.id, rdata: i_r.data, err: i_r.resp == RESP_SLVERR};
    end else if (b_fire) begin
      rsp_q <= '{id: req_q.id, rdata: '0, err: i_b.resp == RESP_SLVERR};
    end
  end

  // ----------------------------------------
  // Channel drive
  // ----------------------------------------
  assign o_ar_valid = state_q == READ_ADDR;
  assign o_ar       = '{addr: req_q.addr, prot: AXIL_PROT_DATA};
  assign o_r_ready  = state_q == READ_DATA;

  assign o_aw_valid = state_q == WRITE_REQ && !aw_done_q;
  assign o_aw       = '{addr: req_q.addr, prot: AXIL_PROT_DATA};
  assign o_w_valid  = state_q == WRITE_REQ && !w_done_q;
  assign o_w        = '{data: req_q.wdata, strb: req_q.wstrb};
  assign o_b_ready  = state_q == WRITE_RESP;

  assign o_rsp_valid = state_q == RESPOND;
  assign o_rsp       = rsp_q;

  // One transaction at a time on the bus
  rd_wr_excl_a: assert property (@(posedge i_aclk) disable iff (i_rst)
    !(o_ar_valid && (o_aw_valid || o_w_valid)))
    else $error("bridge drives read and write address together");

  rsp_stable_a: assert property (@(posedge i_aclk) disable iff (i_rst)
    o_rsp_valid && !i_rsp_ready |=> o_rsp_valid && $stable(o_rsp))
    else $error("bridge response changed while stalled");

endmodule

// ==== src/axil_pkg.sv ====
// AXI-lite widths, response codes and channel payloads; imported by the bridge, slave and top
package axil_pkg;

  // ----------------------------------------
  // Bus geometry
  // ----------------------------------------
  localparam int AXIL_ADDR_W = 32;
  localparam int AXIL_DATA_W = 64;
  localparam int AXIL_STRB_W = AXIL_DATA_W / 8;  // One strobe per byte

  typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
  typedef logic [AXIL_DATA_W-1:0] axil_data_t;
  typedef logic [AXIL_STRB_W-1:0] axil_strb_t;
  typedef logic [1:0]             axil_resp_t;
  typedef logic [2:0]             axil_prot_t;

  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

  // Unprivileged, secure, data access
  localparam axil_prot_t AXIL_PROT_DATA = 3'b000;

  // ----------------------------------------
  // Channel payloads, valid/ready travel alongside
  // ----------------------------------------
  typedef struct packed {
    axil_addr_t addr;
    axil_prot_t prot;
  } axil_aw_t;

  typedef struct packed {
    axil_data_t data;
    axil_strb_t strb;
  } axil_w_t;

  typedef struct packed {
    axil_resp_t resp;
  } axil_b_t;

  typedef struct packed {
    axil_addr_t addr;
    axil_prot_t prot;
  } axil_ar_t;

  typedef struct packed {
    axil_data_t data;
    axil_resp_t resp;
  } axil_r_t;

endpackage

// ==== src/axil_sram_slave.sv ====
// AXI-lite slave over a strobed 64-bit SRAM; out-of-range accesses answer SLVERR
`timescale 1ns/1ps

module axil_sram_slave (
  input  logic               i_aclk,
  input  logic               i_rst,
  input  logic               i_aw_valid,
  output logic               o_aw_ready,
  input  axil_pkg::axil_aw_t i_aw,
  input  logic               i_w_valid,
  output logic               o_w_ready,
  input  axil_pkg::axil_w_t  i_w,
  output logic               o_b_valid,
  input  logic               i_b_ready,
  output axil_pkg::axil_b_t  o_b,
  input  logic               i_ar_valid,
  output logic               o_ar_ready,
  input  axil_pkg::axil_ar_t i_ar,
  output logic               o_r_valid,
  input  logic               i_r_ready,
  output axil_pkg::axil_r_t  o_r
);
  import axil_pkg::*;
  import mem_req_pkg::*;

  axil_data_t mem_q [SRAM_WORDS];
  axil_aw_t   aw_q;
  axil_w_t    w_q;
  axil_b_t    b_q;
  axil_r_t    r_q;
  logic       aw_full_q;
  logic       w_full_q;
  logic       b_valid_q;
  logic       r_valid_q;
  logic       wr_commit;

  function automatic logic addr_in_range(axil_addr_t addr);
    return addr[AXIL_ADDR_W-1:SRAM_IDX_W+WORD_BYTE_W] == '0;
  endfunction

  function automatic sram_idx_t addr_to_idx(axil_addr_t addr);
    return addr[SRAM_IDX_W+WORD_BYTE_W-1:WORD_BYTE_W];
  endfunction

  assign o_aw_ready = !aw_full_q;
  assign o_w_ready  = !w_full_q;
  assign o_ar_ready = !r_valid_q;   // Single-entry read response
  assign wr_commit  = aw_full_q && w_full_q && !b_valid_q;

  // ----------------------------------------
  // Channel bookkeeping
  // ----------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      aw_full_q <= 1'b0;
      w_full_q  <= 1'b0;
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (i_aw_valid && o_aw_ready) aw_full_q <= 1'b1;
      if (i_w_valid && o_w_ready) w_full_q <= 1'b1;
      if (wr_commit) begin
        aw_full_q <= 1'b0;
        w_full_q  <= 1'b0;
        b_valid_q <= 1'b1;
      end else if (i_b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (i_ar_valid && o_ar_ready) begin
        r_valid_q <= 1'b1;
      end else if (i_r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_aclk) begin
    if (i_aw_valid && o_aw_ready) aw_q <= i_aw;
    if (i_w_valid && o_w_ready) w_q <= i_w;
    if (wr_commit) begin
      b_q.resp <= addr_in_range(aw_q.addr) ? RESP_OKAY : RESP_SLVERR;
    end
    if (i_ar_valid && o_ar_ready) begin
      if (addr_in_range(i_ar.addr)) begin
        r_q <= '{data: mem_q[addr_to_idx(i_ar.addr)], resp: RESP_OKAY};
      end else begin
        r_q <= '{data: '0, resp: RESP_SLVERR};  // Miss reads as zero
      end
    end
  end

  // ----------------------------------------
  // Storage, byte-strobed write
  // ----------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      for (int i = 0; i < SRAM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_commit && addr_in_range(aw_q.addr)) begin
      for (int b = 0; b < AXIL_STRB_W; b++) begin
        if (w_q.strb[b]) mem_q[addr_to_idx(aw_q.addr)][b*8 +: 8] <= w_q.data[b*8 +: 8];
      end
    end
  end

  assign o_b_valid = b_valid_q;
  assign o_b       = b_q;
  assign o_r_valid = r_valid_q;
  assign o_r       = r_q;

  r_stable_a: assert property (@(posedge i_aclk) disable iff (i_rst)
    o_r_valid && !i_r_ready |=> o_r_valid && $stable(o_r))
    else $error("slave read data changed while stalled");

endmodule

// ==== src/mem_port_arbiter.sv ====
// Round-robin arbiter between fetch and data ports; registers the grant and routes responses by id
`timescale 1ns/1ps

module mem_port_arbiter (
  input  logic                     i_aclk,
  input  logic                     i_rst,
  input  logic                     i_fetch_req_valid,
  output logic                     o_fetch_req_ready,
  input  mem_req_pkg::fetch_req_t  i_fetch_req,
  input  logic                     i_data_req_valid,
  output logic                     o_data_req_ready,
  input  mem_req_pkg::data_req_t   i_data_req,
  output logic                     o_req_valid,
  input  logic                     i_req_ready,
  output mem_req_pkg::mem_req_t    o_req,
  input  logic                     i_rsp_valid,
  output logic                     o_rsp_ready,
  input  mem_req_pkg::mem_rsp_t    i_rsp,
  output logic                     o_fetch_rsp_valid,
  input  logic                     i_fetch_rsp_ready,
  output mem_req_pkg::client_rsp_t o_fetch_rsp,
  output logic                     o_data_rsp_valid,
  input  logic                     i_data_rsp_ready,
  output mem_req_pkg::client_rsp_t o_data_rsp
);
  import mem_req_pkg::*;

  logic       req_valid_q;
  mem_req_t   req_q;
  mem_req_t   req_next;
  client_id_e last_grant_q;
  logic       slot_free;
  logic       grant_fetch;
  logic       grant_data;

  // ----------------------------------------
  // Request side
  // ----------------------------------------
  assign slot_free   = !req_valid_q || i_req_ready;  // Empty or draining now
  assign grant_data  = i_data_req_valid && (!i_fetch_req_valid || last_grant_q == CLIENT_FETCH);
  assign grant_fetch = i_fetch_req_valid && !grant_data;

  assign o_fetch_req_ready = slot_free && grant_fetch;
  assign o_data_req_ready  = slot_free && grant_data;

  always_comb begin
    if (grant_data) begin
      req_next.id    = CLIENT_DATA;
      req_next.write = i_data_req.write;
      req_next.addr  = i_data_req.addr;
      req_next.wdata = i_data_req.wdata;
      req_next.wstrb = i_data_req.wstrb;
    end else begin
      req_next.id    = CLIENT_FETCH;
      req_next.write = 1'b0;  // Fetch is read only
      req_next.addr  = i_fetch_req.addr;
      req_next.wdata = '0;
      req_next.wstrb = '0;
    end
  end

  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      req_valid_q  <= 1'b0;
      last_grant_q <= CLIENT_DATA;  // Fetch gets the first tie
    end else if (slot_free) begin
      req_valid_q <= grant_fetch || grant_data;
      if (grant_fetch || grant_data) begin
        last_grant_q <= req_next.id;
      end
    end
  end

  always_ff @(posedge i_aclk) begin
    if (slot_free && (grant_fetch || grant_data)) begin
      req_q <= req_next;
    end
  end

  assign o_req_valid = req_valid_q;
  assign o_req       = req_q;

  // ----------------------------------------
  // Response demux, no per-request state
  // ----------------------------------------
  assign o_fetch_rsp_valid = i_rsp_valid && i_rsp.id == CLIENT_FETCH;
  assign o_data_rsp_valid  = i_rsp_valid && i_rsp.id == CLIENT_DATA;
  assign o_fetch_rsp       = '{rdata: i_rsp.rdata, err: i_rsp.err};
  assign o_data_rsp        = '{rdata: i_rsp.rdata, err: i_rsp.err};
  assign o_rsp_ready       = i_rsp_valid &&
                             (i_rsp.id == CLIENT_FETCH ? i_fetch_rsp_ready : i_data_rsp_ready);

  // Held request must not move under bridge back-pressure
  req_stable_a: assert property (@(posedge i_aclk) disable iff (i_rst)
    o_req_valid && !i_req_ready |=> o_req_valid && $stable(o_req))
    else $error("arbiter request changed while stalled");

endmodule

// ==== src/mem_req_pkg.sv ====
// Core-side request and response payloads, client ids and SRAM geometry for all memory stages
package mem_req_pkg;

  typedef enum logic [0:0] {
    CLIENT_FETCH = 1'b0,
    CLIENT_DATA  = 1'b1
  } client_id_e;

  // SRAM map: word index is addr[10:3], anything at 2048 or above misses
  localparam int SRAM_WORDS  = 256;
  localparam int SRAM_IDX_W  = 8;
  localparam int WORD_BYTE_W = 3;  // Byte offset inside a word

  typedef logic [SRAM_IDX_W-1:0] sram_idx_t;

  typedef struct packed {
    axil_pkg::axil_addr_t addr;
  } fetch_req_t;

  typedef struct packed {
    logic                 write;
    axil_pkg::axil_addr_t addr;
    axil_pkg::axil_data_t wdata;
    axil_pkg::axil_strb_t wstrb;
  } data_req_t;

  // Unified request from arbiter to bridge
  typedef struct packed {
    client_id_e           id;
    logic                 write;
    axil_pkg::axil_addr_t addr;
    axil_pkg::axil_data_t wdata;
    axil_pkg::axil_strb_t wstrb;
  } mem_req_t;

  typedef struct packed {
    client_id_e           id;
    axil_pkg::axil_data_t rdata;
    logic                 err;  // Slave answered SLVERR
  } mem_rsp_t;

  typedef struct packed {
    axil_pkg::axil_data_t rdata;
    logic                 err;
  } client_rsp_t;

endpackage

// ==== src/mem_subsystem_top.sv ====
// Memory subsystem top; chains the port arbiter, AXI-lite master bridge and SRAM slave
`timescale 1ns/1ps

module mem_subsystem_top (
  input  logic                     i_aclk,
  input  logic                     i_rst,
  input  logic                     i_fetch_req_valid,
  output logic                     o_fetch_req_ready,
  input  mem_req_pkg::fetch_req_t  i_fetch_req,
  input  logic                     i_data_req_valid,
  output logic                     o_data_req_ready,
  input  mem_req_pkg::data_req_t   i_data_req,
  output logic                     o_fetch_rsp_valid,
  input  logic                     i_fetch_rsp_ready,
  output mem_req_pkg::client_rsp_t o_fetch_rsp,
  output logic                     o_data_rsp_valid,
  input  logic                     i_data_rsp_ready,
  output mem_req_pkg::client_rsp_t o_data_rsp
);
  import axil_pkg::*;
  import mem_req_pkg::*;

  // Arbiter to bridge
  logic     req_valid;
  logic     req_ready;
  mem_req_t req;
  logic     rsp_valid;
  logic     rsp_ready;
  mem_rsp_t rsp;

  // ----------------------------------------
  // AXI-lite between bridge and slave
  // ----------------------------------------
  logic     aw_valid, aw_ready;
  axil_aw_t aw;
  logic     w_valid, w_ready;
  axil_w_t  w;
  logic     b_valid, b_ready;
  axil_b_t  b;
  logic     ar_valid, ar_ready;
  axil_ar_t ar;
  logic     r_valid, r_ready;
  axil_r_t  r;

  mem_port_arbiter mem_port_arbiter_i (
    .i_aclk(i_aclk), .i_rst(i_rst),
    .i_fetch_req_valid(i_fetch_req_valid), .o_fetch_req_ready(o_fetch_req_ready),
    .i_fetch_req(i_fetch_req),
    .i_data_req_valid(i_data_req_valid), .o_data_req_ready(o_data_req_ready),
    .i_data_req(i_data_req),
    .o_req_valid(req_valid), .i_req_ready(req_ready), .o_req(req),
    .i_rsp_valid(rsp_valid), .o_rsp_ready(rsp_ready), .i_rsp(rsp),
    .o_fetch_rsp_valid(o_fetch_rsp_valid), .i_fetch_rsp_ready(i_fetch_rsp_ready),
    .o_fetch_rsp(o_fetch_rsp),
    .o_data_rsp_valid(o_data_rsp_valid), .i_data_rsp_ready(i_data_rsp_ready),
    .o_data_rsp(o_data_rsp)
  );

  axil_master_bridge axil_master_bridge_i (
    .i_aclk(i_aclk), .i_rst(i_rst),
    .i_req_valid(req_valid), .o_req_ready(req_ready), .i_req(req),
    .o_rsp_valid(rsp_valid), .i_rsp_ready(rsp_ready), .o_rsp(rsp),
    .o_aw_valid(aw_valid), .i_aw_ready(aw_ready), .o_aw(aw),
    .o_w_valid(w_valid), .i_w_ready(w_ready), .o_w(w),
    .i_b_valid(b_valid), .o_b_ready(b_ready), .i_b(b),
    .o_ar_valid(ar_valid), .i_ar_ready(ar_ready), .o_ar(ar),
    .i_r_valid(r_valid), .o_r_ready(r_ready), .i_r(r)
  );

  axil_sram_slave axil_sram_slave_i (
    .i_aclk(i_aclk), .i_rst(i_rst),
    .i_aw_valid(aw_valid), .o_aw_ready(aw_ready), .i_aw(aw),
    .i_w_valid(w_valid), .o_w_ready(w_ready), .i_w(w),
    .o_b_valid(b_valid), .i_b_ready(b_ready), .o_b(b),
    .i_ar_valid(ar_valid), .o_ar_ready(ar_ready), .i_ar(ar),
    .o_r_valid(r_valid), .i_r_ready(r_ready), .o_r(r)
  );

endmodule

// ==== test/tb_mem_subsystem.sv ====
// Testbench for the memory subsystem; random fetch and data traffic checked against a reference SRAM
`timescale 1ns/1ps

module tb_mem_subsystem;
  import axil_pkg::*;
  import mem_req_pkg::*;

  localparam int CLK_PERIOD     = 4;
  localparam int RESET_CYCLES   = 8;
  localparam int N_FETCH        = 150;
  localparam int N_DATA         = 150;
  localparam int CYCLES_PER_REQ = 12;  // Slow pace under heavy back-pressure
  localparam int TIMEOUT_CYCLES = (N_FETCH + N_DATA) * CYCLES_PER_REQ + 400;
  localparam int SRAM_BYTES     = SRAM_WORDS * 8;

  logic        i_aclk = 1'b0;
  logic        i_rst  = 1'b1;
  logic        i_fetch_req_valid;
  logic        o_fetch_req_ready;
  fetch_req_t  i_fetch_req;
  logic        i_data_req_valid;
  logic        o_data_req_ready;
  data_req_t   i_data_req;
  logic        o_fetch_rsp_valid;
  logic        i_fetch_rsp_ready;
  client_rsp_t o_fetch_rsp;
  logic        o_data_rsp_valid;
  logic        i_data_rsp_ready;
  client_rsp_t o_data_rsp;

  // Reference SRAM and per-port expected responses
  axil_data_t  ref_mem [SRAM_WORDS];
  client_rsp_t exp_q [2][$];
  logic        held [2];      // Response stalled at the last edge
  client_rsp_t held_rsp [2];
  data_req_t   data_plan_q [$];
  axil_addr_t  last_wr_addr;
  logic        fetch_fire = 1'b0;
  logic        data_fire  = 1'b0;
  logic        last_grant_fetch = 1'b0;
  logic        stim_on = 1'b0;
  integer      seed;
  int          cycle_count = 0;
  int          fetch_issued = 0;
  int          data_issued = 0;

  always #(CLK_PERIOD / 2) i_aclk = ~i_aclk;

  mem_subsystem_top mem_subsystem_top_i (
    .i_aclk(i_aclk), .i_rst(i_rst),
    .i_fetch_req_valid(i_fetch_req_valid), .o_fetch_req_ready(o_fetch_req_ready),
    .i_fetch_req(i_fetch_req),
    .i_data_req_valid(i_data_req_valid), .o_data_req_ready(o_data_req_ready),
    .i_data_req(i_data_req),
    .o_fetch_rsp_valid(o_fetch_rsp_valid), .i_fetch_rsp_ready(i_fetch_rsp_ready),
    .o_fetch_rsp(o_fetch_rsp),
    .o_data_rsp_valid(o_data_rsp_valid), .i_data_rsp_ready(i_data_rsp_ready),
    .o_data_rsp(o_data_rsp)
  );

  // ----------------------------------------
  // Failure reporting
  // ----------------------------------------
  task automatic stop_run(input string line);
    $display("%s", line);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string msg);
    stop_run($sformatf("[ERROR] %0t ns: %s", $time, msg));
  endtask

  // ----------------------------------------
  // Reference model and checks
  // ----------------------------------------
  task automatic apply_request(input client_id_e id, input logic write, input axil_addr_t addr,
                               input axil_data_t wdata, input axil_strb_t wstrb);
    client_rsp_t expected;
    logic        hit;
    hit            = addr < SRAM_BYTES;
    expected.err   = !hit;
    expected.rdata = '0;  // Writes and misses return zero
    if (hit && write) begin
      for (int b = 0; b < AXIL_STRB_W; b++) begin
        if (wstrb[b]) ref_mem[addr[10:3]][b*8 +: 8] = wdata[b*8 +: 8];
      end
    end else if (hit) begin
      expected.rdata = ref_mem[addr[10:3]];
    end
    exp_q[id].push_back(expected);
  endtask

  task automatic check_response(input client_id_e p, input string name, input logic valid,
                                input logic ready, input client_rsp_t rsp);
    client_rsp_t expected;
    if (!valid) begin
      assert (!held[p]) else stop_run({name, " response valid dropped before its transfer"});
    end else begin
      assert (exp_q[p].size() != 0)
        else stop_run({name, " response arrived with no request outstanding"});
      expected = exp_q[p][0];
      if (held[p]) begin
        assert (rsp == held_rsp[p])
          else report_mismatch($sformatf("%s response changed under back-pressure", name));
      end
      assert (rsp == expected)
        else report_mismatch($sformatf("%s response rdata %h err %b, expected rdata %h err %b",
                                       name, rsp.rdata, rsp.err, expected.rdata, expected.err));
      if (ready) begin
        void'(exp_q[p].pop_front());
        held[p] = 1'b0;
      end else begin
        held[p]     = 1'b1;
        held_rsp[p] = rsp;
      end
    end
  endtask

  task automatic check_grant();
    assert (!(fetch_fire && data_fire)) else report_mismatch("both request ports accepted at once");
    if (fetch_fire || data_fire) begin
      // A tie goes to the port not granted last
      if (i_fetch_req_valid && i_data_req_valid) begin
        assert (fetch_fire != last_grant_fetch)
          else report_mismatch($sformatf("%s port won two ties in a row",
                                         fetch_fire ? "fetch" : "data"));
      end
      last_grant_fetch = fetch_fire;
    end
  endtask

  // Handshakes are settled half a cycle after the drive point
  always @(negedge i_aclk) begin
    fetch_fire = i_fetch_req_valid && o_fetch_req_ready;
    data_fire  = i_data_req_valid && o_data_req_ready;
    if (cycle_count > 0 && !stim_on) begin
      assert (!o_fetch_rsp_valid && !o_data_rsp_valid && !o_fetch_req_ready && !o_data_req_ready)
        else report_mismatch("client-side handshake output high around reset");
    end
    if (!i_rst) begin
      check_response(CLIENT_FETCH, "fetch", o_fetch_rsp_valid, i_fetch_rsp_ready, o_fetch_rsp);
      check_response(CLIENT_DATA, "data", o_data_rsp_valid, i_data_rsp_ready, o_data_rsp);
      check_grant();
      if (fetch_fire) apply_request(CLIENT_FETCH, 1'b0, i_fetch_req.addr, '0, '0);
      if (data_fire) begin
        apply_request(CLIENT_DATA, i_data_req.write, i_data_req.addr, i_data_req.wdata,
                      i_data_req.wstrb);
      end
    end
  end

  always @(posedge i_aclk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      stop_run($sformatf("Timeout after %0d cycles with %0d fetch and %0d data responses missing",
                         cycle_count, exp_q[CLIENT_FETCH].size(), exp_q[CLIENT_DATA].size()));
    end
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  task automatic drive_step();
    data_req_t   req;
    axil_addr_t  addr;
    logic [31:0] rnd;
    if (fetch_fire) i_fetch_req_valid = 1'b0;
    if (!i_fetch_req_valid && fetch_issued < N_FETCH && ({$random(seed)} % 4) != 0) begin
      rnd = {$random(seed)} % 16;
      if (rnd == 0) addr = $random(seed) | 32'h800;   // Out of range
      else if (rnd < 8) addr = last_wr_addr;          // Chase recent writes
      else addr = {$random(seed)} % SRAM_BYTES;
      i_fetch_req.addr  = addr;
      i_fetch_req_valid = 1'b1;
      fetch_issued++;
    end

    if (data_fire) i_data_req_valid = 1'b0;
    if (data_plan_q.size() == 0 && data_issued < N_DATA) begin
      rnd = $random(seed);
      if (rnd[2:0] == 3'd0) addr = $random(seed) | 32'h800;
      else addr = {$random(seed)} % SRAM_BYTES;
      req.write = 1'b1;
      req.addr  = addr;
      req.wdata = {$random(seed), $random(seed)};
      req.wstrb = rnd[15:8];
      data_plan_q.push_back(req);
      req.write = 1'b0;  // Read back the same word
      req.wstrb = '0;
      data_plan_q.push_back(req);
      if (addr >= SRAM_BYTES) begin
        req.addr = addr & (SRAM_BYTES - 1);  // Alias inside the SRAM stays untouched
        data_plan_q.push_back(req);
      end
      last_wr_addr = addr;
    end
    if (!i_data_req_valid && data_plan_q.size() != 0 && ({$random(seed)} % 4) != 0) begin
      i_data_req       = data_plan_q.pop_front();
      i_data_req_valid = 1'b1;
      data_issued++;
    end

    // Ready low about a third of the time
    i_fetch_rsp_ready = ({$random(seed)} % 3) != 0;
    i_data_rsp_ready  = ({$random(seed)} % 3) != 0;
  endtask

  function automatic logic run_complete();
    return fetch_issued == N_FETCH && data_issued >= N_DATA && data_plan_q.size() == 0 &&
           !i_fetch_req_valid && !i_data_req_valid &&
           exp_q[CLIENT_FETCH].size() == 0 && exp_q[CLIENT_DATA].size() == 0;
  endfunction

  initial begin
    seed              = 32'h519c;
    i_fetch_req_valid = 1'b0;
    i_fetch_req       = '0;
    i_data_req_valid  = 1'b0;
    i_data_req        = '0;
    i_fetch_rsp_ready = 1'b0;
    i_data_rsp_ready  = 1'b0;
    held[0]           = 1'b0;
    held[1]           = 1'b0;
    last_wr_addr      = '0;
    for (int i = 0; i < SRAM_WORDS; i++) begin
      ref_mem[i] = '0;
    end

    repeat (RESET_CYCLES) @(posedge i_aclk);
    #1;
    i_rst = 1'b0;
    repeat (2) @(posedge i_aclk);
    #1;
    stim_on = 1'b1;
    while (!run_complete()) begin
      drive_step();
      @(posedge i_aclk);
      #1;
    end

    // Idle tail catches a duplicated response
    i_fetch_rsp_ready = 1'b1;
    i_data_rsp_ready  = 1'b1;
    repeat (10) @(posedge i_aclk);
    $display("Checked %0d fetch and %0d data requests", fetch_issued, data_issued);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule
